//--- logic/corePkg.sv
`default_nettype none

package corePkg;

    localparam int xlen        = 32;
    localparam int regAddrBits = 5;
    localparam int laneCount   = 2;

    localparam int aluOpBits = 4;
    localparam logic [aluOpBits-1:0] aluAdd  = 4'd0;
    localparam logic [aluOpBits-1:0] aluSub  = 4'd1;
    localparam logic [aluOpBits-1:0] aluAnd  = 4'd2;
    localparam logic [aluOpBits-1:0] aluOr   = 4'd3;
    localparam logic [aluOpBits-1:0] aluXor  = 4'd4;
    localparam logic [aluOpBits-1:0] aluSll  = 4'd5;
    localparam logic [aluOpBits-1:0] aluSrl  = 4'd6;
    localparam logic [aluOpBits-1:0] aluSra  = 4'd7;
    localparam logic [aluOpBits-1:0] aluSlt  = 4'd8;
    localparam logic [aluOpBits-1:0] aluSltu = 4'd9;

    localparam int fwdSelBits = 3;
    localparam logic [fwdSelBits-1:0] fwdNone = 3'd0;
    localparam logic [fwdSelBits-1:0] fwdMemA = 3'd1;
    localparam logic [fwdSelBits-1:0] fwdMemB = 3'd2;
    localparam logic [fwdSelBits-1:0] fwdWbA  = 3'd3;
    localparam logic [fwdSelBits-1:0] fwdWbB  = 3'd4;

endpackage

`default_nettype wire

//--- logic/isaPkg.sv
`default_nettype none

package isaPkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sType;

    // one word, three views
    typedef union packed {
        rType r;
        iType i;
        sType s;
    } instrWord;

    localparam logic [6:0] opOp    = 7'b0110011;
    localparam logic [6:0] opOpImm = 7'b0010011;
    localparam logic [6:0] opLui   = 7'b0110111;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opHalt  = 7'b0001011; // custom-0

    localparam logic [31:0] nopWord = 32'h00000013; // addi x0,x0,0

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt  = 7'b0100000; // sub, sra

endpackage

`default_nettype wire

//--- logic/retireBus.sv
`default_nettype none

interface retireBus import corePkg::*; ();

    logic [laneCount-1:0]                  writeEnable;
    logic [laneCount-1:0][regAddrBits-1:0] dest;
    logic [laneCount-1:0][xlen-1:0]        value;
    logic                                  halt;

    modport source (output writeEnable, output dest, output value, output halt);
    modport sink   (input writeEnable, input dest, input value, input halt);

endinterface

`default_nettype wire

//--- logic/alu.sv
`default_nettype none

module alu import corePkg::*; (
    input  wire logic [xlen-1:0]      operandA,
    input  wire logic [xlen-1:0]      operandB,
    input  wire logic [aluOpBits-1:0] aluOp,
    output logic      [xlen-1:0]      result
);

    logic [4:0] shamt;

    assign shamt = operandB[4:0];

    always_comb begin
        case (aluOp)
            aluSub:  result = operandA - operandB;
            aluAnd:  result = operandA & operandB;
            aluOr:   result = operandA | operandB;
            aluXor:  result = operandA ^ operandB;
            aluSll:  result = operandA << shamt;
            aluSrl:  result = operandA >> shamt;
            aluSra:  result = $signed(operandA) >>> shamt;
            aluSlt:  result = {{(xlen-1){1'b0}}, $signed(operandA) < $signed(operandB)};
            aluSltu: result = {{(xlen-1){1'b0}}, operandA < operandB};
            default: result = operandA + operandB; // add, lui, store address
        endcase
    end

endmodule

`default_nettype wire

//--- logic/registerFile.sv
`default_nettype none

module registerFile import corePkg::*; (
    input  wire logic                              clock,
    input  wire logic                              reset,
    retireBus.sink                                 retire,
    input  wire logic [2*laneCount-1:0][regAddrBits-1:0] readIndex,
    output logic      [2*laneCount-1:0][xlen-1:0]  readValue
);

    logic [xlen-1:0] regs [32];

    // lane B written last so it wins on a clash
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < laneCount; l++) begin
                if (retire.writeEnable[l] && retire.dest[l] != '0) begin
                    regs[retire.dest[l]] <= retire.value[l];
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2*laneCount; p++) begin
            readValue[p] = regs[readIndex[p]];
            for (int l = 0; l < laneCount; l++) begin
                if (retire.writeEnable[l] && retire.dest[l] == readIndex[p]) begin
                    readValue[p] = retire.value[l]; // write-through
                end
            end
            if (readIndex[p] == '0) readValue[p] = '0;
        end
    end

endmodule

`default_nettype wire

//--- logic/fetchUnit.sv
`default_nettype none

module fetchUnit import corePkg::*; import isaPkg::*; (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire instrWord        fetchWordA,
    input  wire instrWord        fetchWordB,
    input  wire logic            hold,
    input  wire logic            halted,
    output logic      [xlen-1:0] fetchAddress,
    output instrWord             packetA,
    output instrWord             packetB,
    output logic      [xlen-1:0] packetPc
);

    logic [xlen-1:0] pc;
    logic            splitA;

    // memory ops only issue in lane B
    assign splitA = fetchWordA.r.opcode == opStore;
    assign fetchAddress = pc;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (!hold && !halted) begin
            pc <= pc + (splitA ? xlen'(4) : xlen'(8));
        end
    end

    // --------------------
    // fetch/decode register
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            packetA  <= nopWord;
            packetB  <= nopWord;
            packetPc <= '0;
        end else if (hold) begin
            packetA <= nopWord; // A already issued, B stays
        end else if (splitA) begin
            packetA  <= nopWord;
            packetB  <= fetchWordA;
            packetPc <= pc;
        end else begin
            packetA  <= fetchWordA;
            packetB  <= fetchWordB;
            packetPc <= pc;
        end
    end

endmodule

`default_nettype wire

//--- logic/decodeStage.sv
`default_nettype none

module decodeStage import corePkg::*; import isaPkg::*; (
    input  wire logic     clock,
    input  wire logic     reset,
    input  wire instrWord packetA,
    input  wire instrWord packetB,
    retireBus.sink        retire,
    output logic          hold,
    output logic [laneCount-1:0][aluOpBits-1:0]   aluOp,
    output logic [laneCount-1:0]                  useImm,
    output logic [laneCount-1:0][xlen-1:0]        rs1Value,
    output logic [laneCount-1:0][xlen-1:0]        rs2Value,
    output logic [laneCount-1:0][xlen-1:0]        imm,
    output logic [laneCount-1:0][regAddrBits-1:0] rs1Index,
    output logic [laneCount-1:0][regAddrBits-1:0] rs2Index,
    output logic [laneCount-1:0][regAddrBits-1:0] dest,
    output logic [laneCount-1:0]                  writeEnable,
    output logic [laneCount-1:0]                  isStore,
    output logic [laneCount-1:0]                  isLui,
    output logic [laneCount-1:0]                  isHalt
);

    instrWord                              slot [laneCount];
    logic [laneCount-1:0][aluOpBits-1:0]   dAluOp;
    logic [laneCount-1:0]                  dUseImm, dWe, dStore, dLui, dHalt, laneKeep;
    logic [laneCount-1:0][xlen-1:0]        dImm;
    logic [laneCount-1:0][regAddrBits-1:0] dRs1, dRs2, dRd;
    logic [2*laneCount-1:0][regAddrBits-1:0] readIndex;
    logic [2*laneCount-1:0][xlen-1:0]      readValue;

    function automatic logic [aluOpBits-1:0] aluFor(input logic [2:0] f3, input logic alt,
                                                    input logic isReg);
        case (f3)
            f3AddSub: return (isReg && alt) ? aluSub : aluAdd;
            f3Sll:    return aluSll;
            f3Slt:    return aluSlt;
            f3Sltu:   return aluSltu;
            f3Xor:    return aluXor;
            f3SrlSra: return alt ? aluSra : aluSrl;
            f3Or:     return aluOr;
            default:  return aluAnd;
        endcase
    endfunction

    assign slot[0] = packetA;
    assign slot[1] = packetB;

    always_comb begin
        for (int l = 0; l < laneCount; l++) begin
            dRs1[l] = slot[l].r.rs1;
            dRs2[l] = slot[l].r.rs2;
            dRd[l] = slot[l].r.rd;
            dAluOp[l] = aluAdd;
            dUseImm[l] = 1'b0;
            dImm[l] = '0;
            dWe[l] = 1'b0;
            dStore[l] = 1'b0;
            dLui[l] = 1'b0;
            dHalt[l] = 1'b0;
            case (slot[l].r.opcode)
                opOp: begin
                    dWe[l] = 1'b1;
                    dAluOp[l] = aluFor(slot[l].r.funct3, slot[l].r.funct7 == f7Alt, 1'b1);
                end
                opOpImm: begin
                    dWe[l] = 1'b1;
                    dUseImm[l] = 1'b1;
                    dRs2[l] = '0;
                    dImm[l] = {{20{slot[l].i.imm[11]}}, slot[l].i.imm};
                    dAluOp[l] = aluFor(slot[l].r.funct3, slot[l].r.funct7 == f7Alt, 1'b0);
                end
                opLui: begin
                    dWe[l] = 1'b1;
                    dUseImm[l] = 1'b1;
                    dLui[l] = 1'b1;
                    dRs1[l] = '0;
                    dRs2[l] = '0;
                    dImm[l] = {slot[l].i.imm, slot[l].i.rs1, slot[l].i.funct3, 12'b0};
                end
                opStore: begin
                    dUseImm[l] = 1'b1;
                    dStore[l] = 1'b1;
                    dRd[l] = '0;
                    dImm[l] = {{20{slot[l].s.immHi[6]}}, slot[l].s.immHi, slot[l].s.immLo};
                end
                default: begin // halt or unknown
                    dHalt[l] = slot[l].r.opcode == opHalt;
                    dRs1[l] = '0;
                    dRs2[l] = '0;
                    dRd[l] = '0;
                end
            endcase
        end
    end

    // A writes something B touches
    assign hold = dWe[0] && dRd[0] != '0 &&
                  (dRd[0] == dRs1[1] || dRd[0] == dRs2[1] || dRd[0] == dRd[1]);
    assign laneKeep = hold ? 2'b01 : 2'b11;

    assign readIndex = {dRs2[1], dRs1[1], dRs2[0], dRs1[0]};

    registerFile i_registerFile (
        .clock(clock),
        .reset(reset),
        .retire(retire),
        .readIndex(readIndex),
        .readValue(readValue)
    );

    // --------------------
    // decode/execute register
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            writeEnable <= '0;
            isStore <= '0;
            isHalt <= '0;
        end else begin
            writeEnable <= dWe & laneKeep;
            isStore <= dStore & laneKeep;
            isHalt <= dHalt & laneKeep;
        end
    end

    always_ff @(posedge clock) begin
        aluOp <= dAluOp;
        useImm <= dUseImm;
        imm <= dImm;
        isLui <= dLui;
        rs1Index <= dRs1;
        rs2Index <= dRs2;
        dest <= dRd;
        rs1Value <= {readValue[2], readValue[0]};
        rs2Value <= {readValue[3], readValue[1]};
    end

endmodule

`default_nettype wire

//--- logic/executeStage.sv
`default_nettype none

module executeStage import corePkg::*; (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic [laneCount-1:0][aluOpBits-1:0]   aluOp,
    input  wire logic [laneCount-1:0]                  useImm,
    input  wire logic [laneCount-1:0][xlen-1:0]        rs1Value,
    input  wire logic [laneCount-1:0][xlen-1:0]        rs2Value,
    input  wire logic [laneCount-1:0][xlen-1:0]        imm,
    input  wire logic [laneCount-1:0][regAddrBits-1:0] rs1Index,
    input  wire logic [laneCount-1:0][regAddrBits-1:0] rs2Index,
    input  wire logic [laneCount-1:0][regAddrBits-1:0] dest,
    input  wire logic [laneCount-1:0]                  writeEnable,
    input  wire logic [laneCount-1:0]                  isStore,
    input  wire logic [laneCount-1:0]                  isLui,
    input  wire logic [laneCount-1:0]                  isHalt,
    retireBus.sink                                     retire,
    output logic [laneCount-1:0][xlen-1:0]             memResult,
    output logic [laneCount-1:0][regAddrBits-1:0]      memDest,
    output logic [laneCount-1:0]                       memWriteEnable,
    output logic [laneCount-1:0]                       memIsHalt,
    output logic [xlen-1:0]                            storeAddress,
    output logic [xlen-1:0]                            storeData,
    output logic                                       storeValid
);

    logic [laneCount-1:0][xlen-1:0] opA, opB, fwdRs2, aluResult;
    logic                           haltPassed;

    // newest producer first, B younger than A
    function automatic logic [fwdSelBits-1:0] pickSource(input logic [regAddrBits-1:0] src);
        if (src == '0) return fwdNone;
        if (memWriteEnable[1] && memDest[1] == src) return fwdMemB;
        if (memWriteEnable[0] && memDest[0] == src) return fwdMemA;
        if (retire.writeEnable[1] && retire.dest[1] == src) return fwdWbB;
        if (retire.writeEnable[0] && retire.dest[0] == src) return fwdWbA;
        return fwdNone;
    endfunction

    function automatic logic [xlen-1:0] forward(input logic [regAddrBits-1:0] src,
                                                input logic [xlen-1:0] regValue);
        case (pickSource(src))
            fwdMemB: return memResult[1];
            fwdMemA: return memResult[0];
            fwdWbB:  return retire.value[1];
            fwdWbA:  return retire.value[0];
            default: return regValue;
        endcase
    endfunction

    always_comb begin
        for (int l = 0; l < laneCount; l++) begin
            fwdRs2[l] = forward(rs2Index[l], rs2Value[l]);
            opA[l] = isLui[l] ? '0 : forward(rs1Index[l], rs1Value[l]);
            opB[l] = useImm[l] ? imm[l] : fwdRs2[l];
        end
    end

    for (genvar l = 0; l < laneCount; l++) begin : g_lane
        alu i_alu (
            .operandA(opA[l]),
            .operandB(opB[l]),
            .aluOp(aluOp[l]),
            .result(aluResult[l])
        );
    end

    assign storeAddress = memResult[1]; // lane B add result

    // --------------------
    // execute/memory register
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            memWriteEnable <= '0;
            memIsHalt <= '0;
            storeValid <= 1'b0;
            haltPassed <= 1'b0;
        end else begin
            memWriteEnable <= writeEnable;
            memIsHalt <= isHalt;
            storeValid <= isStore[1] && !isHalt[0] && !haltPassed; // nothing after halt
            if (isHalt != '0 || retire.halt) haltPassed <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        memResult <= aluResult;
        memDest <= dest;
        storeData <= fwdRs2[1];
    end

endmodule

`default_nettype wire

//--- logic/writebackStage.sv
`default_nettype none

module writebackStage import corePkg::*; (
    input  wire logic                                  clock,
    input  wire logic                                  reset,
    input  wire logic [laneCount-1:0][xlen-1:0]        memResult,
    input  wire logic [laneCount-1:0][regAddrBits-1:0] memDest,
    input  wire logic [laneCount-1:0]                  memWriteEnable,
    input  wire logic [laneCount-1:0]                  memIsHalt,
    retireBus.source                                   retire,
    output logic                                       halted,
    output logic      [xlen-1:0]                       cycleCount
);

    logic [laneCount-1:0][xlen-1:0]        wbValue;
    logic [laneCount-1:0][regAddrBits-1:0] wbDest;
    logic [laneCount-1:0]                  wbWriteEnable, wbIsHalt;
    logic [xlen-1:0]                       counter;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wbWriteEnable <= '0;
            wbIsHalt <= '0;
            halted <= 1'b0;
            counter <= '0;
            cycleCount <= '0;
        end else begin
            wbWriteEnable <= memWriteEnable;
            wbIsHalt <= memIsHalt;
            counter <= counter + 1'b1;
            if (memIsHalt != '0 && !halted) begin
                halted <= 1'b1;       // sticky
                cycleCount <= counter; // first halt only
            end
        end
    end

    always_ff @(posedge clock) begin
        wbValue <= memResult;
        wbDest <= memDest;
    end

    assign retire.writeEnable = wbWriteEnable;
    assign retire.dest = wbDest;
    assign retire.value = wbValue;
    assign retire.halt = wbIsHalt != '0;

endmodule

`default_nettype wire

//--- logic/dualIssueCore.sv
`default_nettype none

module dualIssueCore import corePkg::*; import isaPkg::*; (
    input  wire logic            clock,
    input  wire logic            reset,
    output logic      [xlen-1:0] fetchAddress,
    input  wire logic [31:0]     fetchWordA,
    input  wire logic [31:0]     fetchWordB,
    output logic                 storeValid,
    output logic      [xlen-1:0] storeAddress,
    output logic      [xlen-1:0] storeData,
    output logic                 halted,
    output logic      [xlen-1:0] cycleCount
);

    instrWord packetA, packetB;
    logic     hold;

    logic [laneCount-1:0][aluOpBits-1:0]   aluOp;
    logic [laneCount-1:0]                  useImm, writeEnable, isStore, isLui, isHalt;
    logic [laneCount-1:0][xlen-1:0]        rs1Value, rs2Value, imm, memResult;
    logic [laneCount-1:0][regAddrBits-1:0] rs1Index, rs2Index, dest, memDest;
    logic [laneCount-1:0]                  memWriteEnable, memIsHalt;

    retireBus retire ();

    fetchUnit i_fetch (
        .clock(clock), .reset(reset),
        .fetchWordA(fetchWordA), .fetchWordB(fetchWordB),
        .hold(hold), .halted(halted), .fetchAddress(fetchAddress),
        .packetA(packetA), .packetB(packetB), .packetPc()
    );

    decodeStage i_decode (
        .clock(clock), .reset(reset), .packetA(packetA), .packetB(packetB),
        .retire(retire.sink), .hold(hold), .aluOp(aluOp), .useImm(useImm),
        .rs1Value(rs1Value), .rs2Value(rs2Value), .imm(imm),
        .rs1Index(rs1Index), .rs2Index(rs2Index), .dest(dest),
        .writeEnable(writeEnable), .isStore(isStore), .isLui(isLui), .isHalt(isHalt)
    );

    executeStage i_execute (
        .clock(clock), .reset(reset), .aluOp(aluOp), .useImm(useImm),
        .rs1Value(rs1Value), .rs2Value(rs2Value), .imm(imm),
        .rs1Index(rs1Index), .rs2Index(rs2Index), .dest(dest),
        .writeEnable(writeEnable), .isStore(isStore), .isLui(isLui), .isHalt(isHalt),
        .retire(retire.sink), .memResult(memResult), .memDest(memDest),
        .memWriteEnable(memWriteEnable), .memIsHalt(memIsHalt),
        .storeAddress(storeAddress), .storeData(storeData), .storeValid(storeValid)
    );

    writebackStage i_writeback (
        .clock(clock), .reset(reset), .memResult(memResult), .memDest(memDest),
        .memWriteEnable(memWriteEnable), .memIsHalt(memIsHalt),
        .retire(retire.source), .halted(halted), .cycleCount(cycleCount)
    );

endmodule

`default_nettype wire

//--- include/programTable.svh
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

// fixed program part, the random addi tail and halt follow it
localparam int programWordCount = 19;
localparam logic [31:0] programWords [programWordCount] = '{
    32'h00500093, 32'h00308113, // addi x1,x0,5 / addi x2,x1,3  hazard
    32'h002081B3, 32'h40118233, // add x3,x1,x2 / sub x4,x3,x1  hazard
    32'h00302023, 32'h00402223, // sw x3,0 / sw x4,4  split in slot A
    32'h123452B7, 32'h00409313, // lui x5 / slli x6,x1,4
    32'h401003B3, 32'h4013D413, // sub x7,x0,x1 / srai x8,x7,1
    32'h0013A4B3, 32'h0013B533, // slt x9 / sltu x10
    32'h00708013, 32'h006285B3, // addi x0,x1,7 / add x11,x5,x6
    32'h00B02423, 32'h00802623, // sw x11,8 / sw x8,12
    32'h00902823, 32'h00A02A23, // sw x9,16 / sw x10,20
    32'h00002C23                // sw x0,24
};

localparam int expectedStoreCount = 7;
localparam logic [31:0] expectedStoreAddress [expectedStoreCount] = '{
    32'd0, 32'd4, 32'd8, 32'd12, 32'd16, 32'd20, 32'd24
};
localparam logic [31:0] expectedStoreData [expectedStoreCount] = '{
    32'd13, 32'd8, 32'h12345050, 32'hFFFFFFFD, 32'd1, 32'd0, 32'd0
};

`endif

//--- tb/coreTb.sv
`default_nettype none

module coreTb import isaPkg::*; ();

    `include "programTable.svh"

    localparam int tailCount   = 10; // random addi words on x12
    localparam int totalWords  = programWordCount + tailCount + 4;
    localparam int totalStores = expectedStoreCount + 1;
    localparam int cycleLimit  = 40 + 4 * totalWords;

    logic        clock;
    logic        reset;
    logic [31:0] fetchAddress;
    logic [31:0] fetchWordA;
    logic [31:0] fetchWordB;
    logic        storeValid;
    logic [31:0] storeAddress;
    logic [31:0] storeData;
    logic        halted;
    logic [31:0] cycleCount;

    logic [31:0] instrMem [totalWords];
    logic [31:0] storeAddrTable [totalStores];
    logic [31:0] storeDataTable [totalStores];
    string       storeName [totalStores];
    int          storeIndex;
    int          errorCount;
    int          checkCount;

    dualIssueCore i_dut (
        .clock(clock),
        .reset(reset),
        .fetchAddress(fetchAddress),
        .fetchWordA(fetchWordA),
        .fetchWordB(fetchWordB),
        .storeValid(storeValid),
        .storeAddress(storeAddress),
        .storeData(storeData),
        .halted(halted),
        .cycleCount(cycleCount)
    );

    always #5 clock = ~clock;

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    function automatic logic [31:0] encodeAddi(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm, rs1, f3AddSub, rd, opOpImm};
    endfunction

    function automatic logic [31:0] encodeStore(input logic [4:0] rs2, input logic [4:0] rs1,
                                                input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore}; // sw
    endfunction

    function automatic logic [31:0] instrAt(input logic [31:0] address);
        logic [29:0] index;
        index = address[31:2];
        if (index < 30'(totalWords)) return instrMem[index];
        return nopWord; // past the end of the program
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic buildProgram();
        logic [15:0] lfsr;
        logic [11:0] imm;
        logic [31:0] sum;
        lfsr = 16'd3;
        sum = '0;
        for (int w = 0; w < programWordCount; w++) begin
            instrMem[w] = programWords[w];
        end
        // back-to-back addi chain where every packet is an intra-packet hazard
        for (int t = 0; t < tailCount; t++) begin
            for (int b = 0; b < 12; b++) begin
                lfsr = lfsrStep(lfsr);
                imm[b] = lfsr[0];
            end
            instrMem[programWordCount + t] = encodeAddi(5'd12, 5'd12, imm);
            sum = sum + {{20{imm[11]}}, imm};
        end
        instrMem[programWordCount + tailCount] = encodeStore(5'd12, 5'd0, 12'd28);
        instrMem[programWordCount + tailCount + 1] = {25'd0, opHalt};
        // stores behind halt must never leave the core
        instrMem[programWordCount + tailCount + 2] = encodeStore(5'd12, 5'd0, 12'd32);
        instrMem[programWordCount + tailCount + 3] = encodeStore(5'd12, 5'd0, 12'd36);

        for (int s = 0; s < expectedStoreCount; s++) begin
            storeAddrTable[s] = expectedStoreAddress[s];
            storeDataTable[s] = expectedStoreData[s];
        end
        storeAddrTable[expectedStoreCount] = 32'd28;
        storeDataTable[expectedStoreCount] = sum;
        storeName = '{"split store x3", "split store x4", "lui plus slli", "srai negative",
                      "slt signed", "sltu unsigned", "x0 stays zero", "random addi sum"};
    endtask

    // --------------------
    // instruction memory answers the fetch address
    always @(negedge clock) begin
        fetchWordA <= instrAt(fetchAddress);
        fetchWordB <= instrAt(fetchAddress + 32'd4);
    end

    // --------------------
    // store checker walks the expected list in order
    always @(negedge clock) begin
        if (!reset && storeValid) begin
            if (halted) begin
                errorCount++;
                $display("store pulse seen after halt at address %h", storeAddress);
            end
            if (storeIndex < totalStores) begin
                checkValue($sformatf("%s address", storeName[storeIndex]),
                           storeAddrTable[storeIndex], storeAddress);
                checkValue($sformatf("%s data", storeName[storeIndex]),
                           storeDataTable[storeIndex], storeData);
            end else begin
                errorCount++;
                $display("extra store beyond the expected list, address %h data %h",
                         storeAddress, storeData);
            end
            storeIndex++;
        end
    end

    initial begin
        int          cycles;
        logic [31:0] frozenCount;
        logic [31:0] frozenAddress;
        clock = 1'b0;
        reset = 1'b1;
        fetchWordA = nopWord;
        fetchWordB = nopWord;
        storeIndex = 0;
        errorCount = 0;
        checkCount = 0;
        cycles = 0;
        buildProgram();

        repeat (10) @(negedge clock);
        reset = 1'b0;

        while (!halted && cycles < cycleLimit) begin
            @(negedge clock);
            cycles++;
        end

        if (!halted) begin
            errorCount++;
            $display("halt never arrived within %0d cycles", cycleLimit);
        end else begin
            checkCount++;
            if (cycleCount == '0) begin
                errorCount++;
                $display("Fail halt cycle count expected nonzero actual %h", cycleCount);
            end
            frozenCount = cycleCount;
            frozenAddress = fetchAddress; // pc stops once halted is up
            repeat (10) begin
                @(negedge clock);
                checkValue("frozen cycle count", frozenCount, cycleCount);
                checkValue("frozen fetch address", frozenAddress, fetchAddress);
                checkValue("halted level", 32'd1, {31'd0, halted});
            end
            @(posedge clock); // checker settled on the last falling edge
            checkValue("store count", 32'(totalStores), 32'(storeIndex));
        end

        $display("%0d errors in %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
logic/corePkg.sv
logic/isaPkg.sv
logic/retireBus.sv
logic/alu.sv
logic/registerFile.sv
logic/fetchUnit.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/writebackStage.sv
logic/dualIssueCore.sv
tb/coreTb.sv
+incdir+include

//--- run.sh
#!/usr/bin/env bash
# build the core testbench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f sim.f --top-module coreTb -o coreSim
./obj_dir/coreSim > sim.log 2>&1
cat sim.log

if grep -qx "All checks passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
